/* soc_bus_pkg.sv */
////////////////////
// Bus widths, op codes, slave indices
// and the fixed slave map sizes
////////////////////

package soc_bus_pkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 12;                    // Word address

	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [DATA_W/8-1:0]   sel_t;

	// Code 2'b11 is reserved and lands on the invalid device
	typedef enum logic [1:0] {
		OP_NONE  = 2'b00,
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10
	} pi1_op_e;

	// Order matches the address map from word 0
	typedef enum logic [1:0] {
		SLV_DEVTBL  = 2'd0,
		SLV_GPIO    = 2'd1,
		SLV_RAM     = 2'd2,
		SLV_INVALID = 2'd3
	} slv_e;

	localparam int SLV_COUNT = 4;

	localparam int DEVTBL_WORDS  = 16;
	localparam int GPIO_WORDS    = 16;
	localparam int INVALID_WORDS = 16;           // Reported size only

endpackage

/* soc_ctrl_pkg.sv */
////////////////////
// Reset request codes, device-table layout
////////////////////

package soc_ctrl_pkg;

	// Bit 0 is rst0, bit 1 is rst1
	typedef enum logic [1:0] {
		RST_NONE     = 2'b00,
		RST_POWEROFF = 2'b01,
		RST_WARM     = 2'b10,
		RST_COLD     = 2'b11
	} rst_code_e;

	localparam int RST0_BIT = 0;
	localparam int RST1_BIT = 1;

	localparam int RST_REG_WORD   = 0;            // Reset request register
	localparam int MAP_TABLE_WORD = 1;            // First map-size entry

endpackage

/* pi1_addr_decode.sv */
`timescale 1ns/1ps
////////////////////
// Request register with slave decode
// from the consecutive map sizes
////////////////////

module pi1_addr_decode #(
	parameter int RAM_WORDS = 256
) (
	input  logic                              clk100mhz,
	input  logic                              sys_rst_i,
	input  soc_bus_pkg::pi1_op_e              op_i,
	input  soc_bus_pkg::addr_t                addr_i,
	input  soc_bus_pkg::data_t                wdata_i,
	input  soc_bus_pkg::sel_t                 sel_i,
	output logic [soc_bus_pkg::SLV_COUNT-1:0] slv_sel_o,
	output soc_bus_pkg::slv_e                 slv_idx_o,
	output soc_bus_pkg::addr_t                offset_o,
	output soc_bus_pkg::pi1_op_e              op_o,
	output soc_bus_pkg::data_t                wdata_o,
	output soc_bus_pkg::sel_t                 sel_o
);
	import soc_bus_pkg::*;

	localparam int GPIO_BASE = DEVTBL_WORDS;
	localparam int RAM_BASE  = GPIO_BASE + GPIO_WORDS;
	localparam int RAM_END   = RAM_BASE + RAM_WORDS;

	slv_e                 idx_d;
	addr_t                base_d;
	logic [SLV_COUNT-1:0] sel_d;

	always_comb begin
		idx_d  = SLV_INVALID;
		base_d = '0;
		if (int'(addr_i) < GPIO_BASE) begin
			idx_d = SLV_DEVTBL;
		end else if (int'(addr_i) < RAM_BASE) begin
			idx_d  = SLV_GPIO;
			base_d = addr_t'(GPIO_BASE);
		end else if (int'(addr_i) < RAM_END) begin
			idx_d  = SLV_RAM;
			base_d = addr_t'(RAM_BASE);
		end
		if (op_i != OP_WRITE && op_i != OP_READ)
			idx_d = SLV_INVALID;              // Reserved op too

		sel_d = '0;
		if (op_i != OP_NONE)
			sel_d[idx_d] = 1'b1;
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			slv_sel_o <= '0;
			slv_idx_o <= SLV_INVALID;
			op_o      <= OP_NONE;
		end else begin
			slv_sel_o <= sel_d;
			slv_idx_o <= idx_d;
			op_o      <= op_i;
		end
	end

	always_ff @(posedge clk100mhz) begin
		offset_o <= addr_i - base_d;
		wdata_o  <= wdata_i;
		sel_o    <= sel_i;
	end

	a_one_slave: assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
		$onehot0(slv_sel_o))
		else $error("more than one slave selected");

endmodule

/* rst_sequencer.sv */
`timescale 1ns/1ps
////////////////////
// Reset countdown, software requests
// and power-off latch
////////////////////

module rst_sequencer #(
	parameter int RST_CNT_W = 16
) (
	input  logic                    clk100mhz,
	input  logic                    rst_p,
	input  soc_ctrl_pkg::rst_code_e sw_rst_code_i,
	input  logic                    sw_rst_stb_i,
	output logic                    sys_rst_o
);
	import soc_ctrl_pkg::*;

	logic [RST_CNT_W-1:0] rst_cnt_q;
	logic                 pwr_off_q;
	logic                 rst0;
	logic                 rst1;
	logic                 sw_warm;
	logic                 sw_cold;
	logic                 sw_pwr_off;

	assign rst0 = sw_rst_stb_i && sw_rst_code_i[RST0_BIT];
	assign rst1 = sw_rst_stb_i && sw_rst_code_i[RST1_BIT];

	assign sw_cold    = rst0 && rst1;
	assign sw_warm    = !rst0 && rst1;
	assign sw_pwr_off = rst0 && !rst1;

	// No global set/reset here, so cold restarts like warm
	always_ff @(posedge clk100mhz) begin
		if (rst_p || sw_warm || sw_cold)
			rst_cnt_q <= '1;
		else if (rst_cnt_q != '0)
			rst_cnt_q <= rst_cnt_q - 1'b1;
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p)
			pwr_off_q <= 1'b0;
		else if (sw_pwr_off)
			pwr_off_q <= 1'b1;                // Held until board reset
	end

	assign sys_rst_o = pwr_off_q || (rst_cnt_q != '0);

	a_pwr_off_holds: assert property (@(posedge clk100mhz)
		pwr_off_q && !rst_p |=> pwr_off_q && sys_rst_o)
		else $error("power-off latch released without rst_p");

endmodule

/* devtbl_regs.sv */
`timescale 1ns/1ps
////////////////////
// Device table with reset request register
////////////////////

module devtbl_regs #(
	parameter int RAM_WORDS = 256
) (
	input  logic                    clk100mhz,
	input  logic                    sys_rst_i,
	input  logic                    cs_i,
	input  soc_bus_pkg::pi1_op_e    op_i,
	input  soc_bus_pkg::addr_t      offset_i,
	input  soc_bus_pkg::data_t      wdata_i,
	output soc_bus_pkg::data_t      rdata_o,
	output logic                    done_o,
	output soc_ctrl_pkg::rst_code_e rst_code_o,
	output logic                    rst_stb_o
);
	import soc_bus_pkg::*;
	import soc_ctrl_pkg::*;

	logic  rd_en;
	logic  wr_en;
	addr_t entry;
	data_t map_word;

	assign rd_en = cs_i && (op_i == OP_READ);
	assign wr_en = cs_i && (op_i == OP_WRITE);
	assign entry = offset_i - addr_t'(MAP_TABLE_WORD);

	always_comb begin
		map_word = '0;
		if (int'(offset_i) >= MAP_TABLE_WORD && int'(entry) < SLV_COUNT) begin
			case (slv_e'(entry[1:0]))
				SLV_DEVTBL:  map_word = DATA_W'(DEVTBL_WORDS);
				SLV_GPIO:    map_word = DATA_W'(GPIO_WORDS);
				SLV_RAM:     map_word = DATA_W'(RAM_WORDS);
				SLV_INVALID: map_word = DATA_W'(INVALID_WORDS);
			endcase
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			done_o    <= 1'b0;
			rst_stb_o <= 1'b0;
		end else begin
			done_o    <= rd_en || wr_en;
			rst_stb_o <= wr_en && (offset_i == addr_t'(RST_REG_WORD));
		end
	end

	always_ff @(posedge clk100mhz) begin
		rdata_o    <= rd_en ? map_word : '0;
		rst_code_o <= rst_code_e'(wdata_i[1:0]);  // Qualified by rst_stb_o
	end

endmodule

/* gpio_port.sv */
`timescale 1ns/1ps
////////////////////
// GPIO output register, synchronized input
////////////////////

module gpio_port #(
	parameter int GPIO_W = 16
) (
	input  logic                 clk100mhz,
	input  logic                 sys_rst_i,
	input  logic                 cs_i,
	input  soc_bus_pkg::pi1_op_e op_i,
	input  soc_bus_pkg::addr_t   offset_i,
	input  soc_bus_pkg::data_t   wdata_i,
	input  soc_bus_pkg::sel_t    sel_i,
	output soc_bus_pkg::data_t   rdata_o,
	output logic                 done_o,
	input  logic [GPIO_W-1:0]    gp_i,
	output logic [GPIO_W-1:0]    gp_o
);
	import soc_bus_pkg::*;

	localparam addr_t OUT_WORD = addr_t'(0);
	localparam addr_t IN_WORD  = addr_t'(1);

	logic              rd_en;
	logic              wr_en;
	logic [DATA_W-1:0] wmask;
	logic [GPIO_W-1:0] gp_meta_q;
	logic [GPIO_W-1:0] gp_sync_q;
	data_t             rd_word;

	assign rd_en = cs_i && (op_i == OP_READ);
	assign wr_en = cs_i && (op_i == OP_WRITE);

	always_comb begin
		for (int b = 0; b < DATA_W/8; b++)
			wmask[8*b +: 8] = {8{sel_i[b]}};
	end

	always_ff @(posedge clk100mhz) begin
		gp_meta_q <= gp_i;
		gp_sync_q <= gp_meta_q;
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i)
			gp_o <= '0;
		else if (wr_en && offset_i == OUT_WORD)
			gp_o <= (gp_o & ~wmask[GPIO_W-1:0]) | (wdata_i[GPIO_W-1:0] & wmask[GPIO_W-1:0]);
	end

	always_comb begin
		case (offset_i)
			OUT_WORD: rd_word = DATA_W'(gp_o);
			IN_WORD:  rd_word = DATA_W'(gp_sync_q);
			default:  rd_word = '0;
		endcase
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i)
			done_o <= 1'b0;
		else
			done_o <= rd_en || wr_en;
	end

	always_ff @(posedge clk100mhz)
		rdata_o <= rd_en ? rd_word : '0;

endmodule

/* scratch_ram.sv */
`timescale 1ns/1ps
////////////////////
// Word RAM with byte enables
////////////////////

module scratch_ram #(
	parameter int RAM_WORDS = 256
) (
	input  logic                 clk100mhz,
	input  logic                 sys_rst_i,
	input  logic                 cs_i,
	input  soc_bus_pkg::pi1_op_e op_i,
	input  soc_bus_pkg::addr_t   offset_i,
	input  soc_bus_pkg::data_t   wdata_i,
	input  soc_bus_pkg::sel_t    sel_i,
	output soc_bus_pkg::data_t   rdata_o,
	output logic                 done_o
);
	import soc_bus_pkg::*;

	localparam int IDX_W = $clog2(RAM_WORDS);

	data_t            mem [RAM_WORDS];       // Kept across resets
	logic [IDX_W-1:0] idx;
	logic             rd_en;
	logic             wr_en;

	assign idx   = offset_i[IDX_W-1:0];
	assign rd_en = cs_i && (op_i == OP_READ);
	assign wr_en = cs_i && (op_i == OP_WRITE);

	always_ff @(posedge clk100mhz) begin
		if (wr_en) begin
			for (int b = 0; b < DATA_W/8; b++) begin
				if (sel_i[b])
					mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clk100mhz)
		rdata_o <= rd_en ? mem[idx] : '0;

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i)
			done_o <= 1'b0;
		else
			done_o <= rd_en || wr_en;
	end

endmodule

/* pi1_resp_mux.sv */
`timescale 1ns/1ps
////////////////////
// Response select, invalid-device answer
////////////////////

module pi1_resp_mux (
	input  logic                              clk100mhz,
	input  logic                              sys_rst_i,
	input  soc_bus_pkg::slv_e                 slv_idx_i,
	input  soc_bus_pkg::pi1_op_e              op_i,
	input  logic [soc_bus_pkg::SLV_COUNT-1:0] done_i,
	input  soc_bus_pkg::data_t                rdata_i [soc_bus_pkg::SLV_COUNT],
	output logic                              resp_valid_o,
	output soc_bus_pkg::data_t                rdata_o
);
	import soc_bus_pkg::*;

	slv_e idx_q;
	logic inval_q;

	// Lines up with the slave stage
	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			idx_q   <= SLV_INVALID;
			inval_q <= 1'b0;
		end else begin
			idx_q   <= slv_idx_i;
			inval_q <= (op_i != OP_NONE) && (slv_idx_i == SLV_INVALID);
		end
	end

	assign resp_valid_o = inval_q || done_i[idx_q];
	assign rdata_o      = inval_q ? '0 : rdata_i[idx_q];  // Invalid device reads zero

	a_one_done: assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
		$onehot0({inval_q, done_i}))
		else $error("more than one slave answered");

endmodule

/* soc_fabric_top.sv */
`timescale 1ns/1ps
////////////////////
// Fabric top: reset, decode, slaves
////////////////////

module soc_fabric_top #(
	parameter int RAM_WORDS = 256,
	parameter int GPIO_W    = 16,
	parameter int RST_CNT_W = 16
) (
	input  logic                 clk100mhz,
	input  logic                 rst_p,
	input  soc_bus_pkg::pi1_op_e op_i,
	input  soc_bus_pkg::addr_t   addr_i,
	input  soc_bus_pkg::data_t   wdata_i,
	input  soc_bus_pkg::sel_t    sel_i,
	input  logic [GPIO_W-1:0]    gp_i,
	output logic                 resp_valid_o,
	output soc_bus_pkg::data_t   rdata_o,
	output logic [GPIO_W-1:0]    gp_o,
	output logic                 sys_rst_o
);
	import soc_bus_pkg::*;
	import soc_ctrl_pkg::*;

	rst_code_e            sw_rst_code;
	logic                 sw_rst_stb;
	logic [SLV_COUNT-1:0] slv_sel;
	slv_e                 slv_idx;
	addr_t                slv_offset;
	pi1_op_e              slv_op;
	data_t                slv_wdata;
	sel_t                 slv_be;
	wire [SLV_COUNT-1:0]  slv_done;
	wire data_t           slv_rdata [SLV_COUNT];

	assign slv_done[SLV_INVALID]  = 1'b0;     // Answered in the mux
	assign slv_rdata[SLV_INVALID] = '0;

	rst_sequencer #(.RST_CNT_W (RST_CNT_W)) u_rst_sequencer (
		 .clk100mhz     (clk100mhz)
		,.rst_p         (rst_p)
		,.sw_rst_code_i (sw_rst_code)
		,.sw_rst_stb_i  (sw_rst_stb)
		,.sys_rst_o     (sys_rst_o)
	);

	pi1_addr_decode #(.RAM_WORDS (RAM_WORDS)) u_pi1_addr_decode (
		 .clk100mhz (clk100mhz)
		,.sys_rst_i (sys_rst_o)
		,.op_i      (op_i)
		,.addr_i    (addr_i)
		,.wdata_i   (wdata_i)
		,.sel_i     (sel_i)
		,.slv_sel_o (slv_sel)
		,.slv_idx_o (slv_idx)
		,.offset_o  (slv_offset)
		,.op_o      (slv_op)
		,.wdata_o   (slv_wdata)
		,.sel_o     (slv_be)
	);

	devtbl_regs #(.RAM_WORDS (RAM_WORDS)) u_devtbl_regs (
		 .clk100mhz  (clk100mhz)
		,.sys_rst_i  (sys_rst_o)
		,.cs_i       (slv_sel[SLV_DEVTBL])
		,.op_i       (slv_op)
		,.offset_i   (slv_offset)
		,.wdata_i    (slv_wdata)
		,.rdata_o    (slv_rdata[SLV_DEVTBL])
		,.done_o     (slv_done[SLV_DEVTBL])
		,.rst_code_o (sw_rst_code)
		,.rst_stb_o  (sw_rst_stb)
	);

	gpio_port #(.GPIO_W (GPIO_W)) u_gpio_port (
		 .clk100mhz (clk100mhz)
		,.sys_rst_i (sys_rst_o)
		,.cs_i      (slv_sel[SLV_GPIO])
		,.op_i      (slv_op)
		,.offset_i  (slv_offset)
		,.wdata_i   (slv_wdata)
		,.sel_i     (slv_be)
		,.rdata_o   (slv_rdata[SLV_GPIO])
		,.done_o    (slv_done[SLV_GPIO])
		,.gp_i      (gp_i)
		,.gp_o      (gp_o)
	);

	scratch_ram #(.RAM_WORDS (RAM_WORDS)) u_scratch_ram (
		 .clk100mhz (clk100mhz)
		,.sys_rst_i (sys_rst_o)
		,.cs_i      (slv_sel[SLV_RAM])
		,.op_i      (slv_op)
		,.offset_i  (slv_offset)
		,.wdata_i   (slv_wdata)
		,.sel_i     (slv_be)
		,.rdata_o   (slv_rdata[SLV_RAM])
		,.done_o    (slv_done[SLV_RAM])
	);

	pi1_resp_mux u_pi1_resp_mux (
		 .clk100mhz    (clk100mhz)
		,.sys_rst_i    (sys_rst_o)
		,.slv_idx_i    (slv_idx)
		,.op_i         (slv_op)
		,.done_i       (slv_done)
		,.rdata_i      (slv_rdata)
		,.resp_valid_o (resp_valid_o)
		,.rdata_o      (rdata_o)
	);

endmodule

/* tb_soc.sv */
`timescale 1ns/1ps
////////////////////
// Fabric testbench: clock, stimulus,
// reference model and response checks
////////////////////

module tb_soc;
	import soc_bus_pkg::*;
	import soc_ctrl_pkg::*;

	localparam int RAM_WORDS = 256;
	localparam int GPIO_W    = 16;
	localparam int RST_CNT_W = 4;
	localparam int GPIO_BASE = DEVTBL_WORDS;        // Map is back to back from 0
	localparam int RAM_BASE  = GPIO_BASE + GPIO_WORDS;
	localparam int RAM_END   = RAM_BASE + RAM_WORDS;

	logic              clk100mhz = 1'b0;
	logic              rst_p;
	pi1_op_e           op_i;
	addr_t             addr_i;
	data_t             wdata_i;
	sel_t              sel_i;
	logic [GPIO_W-1:0] gp_i;
	logic              resp_valid_o;
	data_t             rdata_o;
	logic [GPIO_W-1:0] gp_o;
	logic              sys_rst_o;

	data_t             ref_ram [RAM_WORDS];
	logic [GPIO_W-1:0] ref_gp;
	data_t             exp_q [$];
	int                req_edge_q [$];            // Edge that samples each request
	int                cyc = 0;
	logic              skip_resp;                 // Set while a reset request is in flight

	soc_fabric_top #(
		 .RAM_WORDS (RAM_WORDS)
		,.GPIO_W    (GPIO_W)
		,.RST_CNT_W (RST_CNT_W)
	) u_soc_fabric_top (
		 .clk100mhz    (clk100mhz)
		,.rst_p        (rst_p)
		,.op_i         (op_i)
		,.addr_i       (addr_i)
		,.wdata_i      (wdata_i)
		,.sel_i        (sel_i)
		,.gp_i         (gp_i)
		,.resp_valid_o (resp_valid_o)
		,.rdata_o      (rdata_o)
		,.gp_o         (gp_o)
		,.sys_rst_o    (sys_rst_o)
	);

	always #5 clk100mhz = ~clk100mhz;

	always @(posedge clk100mhz)
		cyc++;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_gpio(input string name, input logic [GPIO_W-1:0] got,
		input logic [GPIO_W-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	function automatic data_t merge_bytes(data_t old, data_t wdata, sel_t sel);
		data_t res;
		res = old;
		for (int b = 0; b < DATA_W/8; b++) begin
			if (sel[b])
				res[8*b +: 8] = wdata[8*b +: 8];
		end
		return res;
	endfunction

	// Expected read data of one access, updates the model on writes
	function automatic data_t ref_access(pi1_op_e op, addr_t addr, data_t wdata, sel_t sel);
		int    a;
		data_t rd;
		a  = int'(addr);
		rd = '0;
		if (op == OP_WRITE) begin
			if (a >= RAM_BASE && a < RAM_END)
				ref_ram[a - RAM_BASE] = merge_bytes(ref_ram[a - RAM_BASE], wdata, sel);
			else if (a == GPIO_BASE)
				ref_gp = GPIO_W'(merge_bytes(data_t'(ref_gp), wdata, sel));
		end else if (op == OP_READ) begin
			if (a >= RAM_BASE && a < RAM_END)
				rd = ref_ram[a - RAM_BASE];
			else if (a == GPIO_BASE)
				rd = data_t'(ref_gp);
			else if (a == GPIO_BASE + 1)
				rd = data_t'(gp_i);
			else if (a >= MAP_TABLE_WORD && a < MAP_TABLE_WORD + SLV_COUNT) begin
				case (a - MAP_TABLE_WORD)
					0:       rd = data_t'(DEVTBL_WORDS);
					1:       rd = data_t'(GPIO_WORDS);
					2:       rd = data_t'(RAM_WORDS);
					default: rd = data_t'(INVALID_WORDS);
				endcase
			end
		end
		return rd;                                // Writes and reserved ops answer zero
	endfunction

	task automatic send_req(input pi1_op_e op, input addr_t addr, input data_t wdata,
		input sel_t sel, input bit expect_resp);
		@(posedge clk100mhz);
		#1;
		op_i    = op;
		addr_i  = addr;
		wdata_i = wdata;
		sel_i   = sel;
		if (expect_resp) begin
			exp_q.push_back(ref_access(op, addr, wdata, sel));
			req_edge_q.push_back(cyc + 1);
		end
	endtask

	task automatic idle_bus();
		@(posedge clk100mhz);
		#1;
		op_i = OP_NONE;
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			@(negedge clk100mhz);
			n++;
		end
		if (exp_q.size() != 0)
			fail_run("Timeout: responses still missing");
	endtask

	task automatic wait_sys_rst(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (sys_rst_o !== level && n < limit) begin
			@(negedge clk100mhz);
			n++;
		end
		if (sys_rst_o !== level)
			fail_run(what);
	endtask

	// One response per request, in order, one edge after the sampling edge
	always @(negedge clk100mhz) begin
		if (resp_valid_o === 1'b1 && !skip_resp) begin
			if (exp_q.size() == 0)
				fail_run("Response arrived with no request outstanding");
			else begin
				if (cyc != req_edge_q.pop_front() + 1)
					fail_run("Response did not arrive two cycles after its request");
				check_data("rdata_o", rdata_o, exp_q.pop_front());
			end
		end
	end

	initial begin
		addr_t a;
		void'($urandom(32976));
		rst_p     = 1'b1;
		op_i      = OP_NONE;
		addr_i    = '0;
		wdata_i   = '0;
		sel_i     = '0;
		gp_i      = '0;
		skip_resp = 1'b0;
		ref_gp    = '0;
		repeat (5) @(posedge clk100mhz);
		#1;
		rst_p = 1'b0;
		wait_sys_rst(1'b0, 100, "Timeout: sys_rst_o did not fall after power-on");
		check_data("resp_valid_o", data_t'(resp_valid_o), '0);
		check_gpio("gp_o", gp_o, '0);

		// RAM fill, partial writes, mixed traffic, read back
		for (int i = 0; i < RAM_WORDS; i++)
			send_req(OP_WRITE, addr_t'(RAM_BASE + i), $urandom, 4'hF, 1'b1);
		for (int i = 0; i < 64; i++)
			send_req(OP_WRITE, addr_t'(RAM_BASE + $urandom_range(RAM_WORDS - 1)),
				$urandom, sel_t'($urandom), 1'b1);
		for (int i = 0; i < 64; i++) begin
			a = addr_t'(RAM_BASE + $urandom_range(7));    // Few words, so hazards occur
			if ($urandom_range(1) == 0)
				send_req(OP_WRITE, a, $urandom, sel_t'($urandom), 1'b1);
			else
				send_req(OP_READ, a, '0, '0, 1'b1);
		end
		for (int i = 0; i < RAM_WORDS; i++)
			send_req(OP_READ, addr_t'(RAM_BASE + i), '0, '0, 1'b1);
		idle_bus();
		wait_drain(10);

		// GPIO output register and synchronized input
		send_req(OP_WRITE, addr_t'(GPIO_BASE), 32'h0000_a5c3, 4'hF, 1'b1);
		idle_bus();
		wait_drain(10);
		check_gpio("gp_o", gp_o, ref_gp);
		send_req(OP_WRITE, addr_t'(GPIO_BASE), 32'hffff_1234, 4'b0001, 1'b1);
		send_req(OP_WRITE, addr_t'(GPIO_BASE + 1), 32'hffff_ffff, 4'hF, 1'b1);
		send_req(OP_READ, addr_t'(GPIO_BASE), '0, '0, 1'b1);
		send_req(OP_READ, addr_t'(GPIO_BASE + 2), '0, '0, 1'b1);
		idle_bus();
		wait_drain(10);
		check_gpio("gp_o", gp_o, ref_gp);
		@(posedge clk100mhz);
		#1;
		gp_i = GPIO_W'($urandom);
		repeat (2) @(posedge clk100mhz);
		send_req(OP_READ, addr_t'(GPIO_BASE + 1), '0, '0, 1'b1);
		idle_bus();
		wait_drain(10);

		// Device table, beyond the map, reserved op
		for (int k = 0; k <= SLV_COUNT + 1; k++)
			send_req(OP_READ, addr_t'(k), '0, '0, 1'b1);
		send_req(OP_READ, addr_t'(RAM_END), '0, '0, 1'b1);
		send_req(OP_READ, 12'hfff, '0, '0, 1'b1);
		send_req(OP_WRITE, addr_t'(RAM_END + 5), 32'hdead_beef, 4'hF, 1'b1);
		send_req(pi1_op_e'(2'b11), addr_t'(RAM_BASE), 32'hdead_beef, 4'hF, 1'b1);
		idle_bus();
		repeat (3) @(posedge clk100mhz);
		wait_drain(10);

		// Warm reset clears GPIO, keeps RAM
		skip_resp = 1'b1;
		send_req(OP_WRITE, addr_t'(RST_REG_WORD), data_t'(RST_WARM), 4'hF, 1'b0);
		idle_bus();
		wait_sys_rst(1'b1, 10, "sys_rst_o did not rise after a warm reset request");
		wait_sys_rst(1'b0, 100, "Timeout: sys_rst_o did not fall after warm reset");
		@(posedge clk100mhz);
		#1;
		skip_resp = 1'b0;
		ref_gp    = '0;
		check_gpio("gp_o", gp_o, ref_gp);
		check_data("resp_valid_o", data_t'(resp_valid_o), '0);
		for (int i = 0; i < RAM_WORDS; i++)
			send_req(OP_READ, addr_t'(RAM_BASE + i), '0, '0, 1'b1);
		idle_bus();
		wait_drain(10);

		// Power-off latch holds until rst_p
		skip_resp = 1'b1;
		send_req(OP_WRITE, addr_t'(RST_REG_WORD), data_t'(RST_POWEROFF), 4'hF, 1'b0);
		idle_bus();
		wait_sys_rst(1'b1, 10, "sys_rst_o did not rise after a power-off request");
		for (int i = 0; i < 100; i++) begin
			@(negedge clk100mhz);
			if (sys_rst_o !== 1'b1)
				fail_run("sys_rst_o fell while power-off was latched");
		end
		@(posedge clk100mhz);
		#1;
		rst_p = 1'b1;
		repeat (2) @(posedge clk100mhz);
		#1;
		rst_p = 1'b0;
		wait_sys_rst(1'b0, 100, "Timeout: sys_rst_o did not fall after rst_p pulse");
		@(posedge clk100mhz);
		#1;
		skip_resp = 1'b0;
		check_gpio("gp_o", gp_o, '0);
		send_req(OP_READ, addr_t'(MAP_TABLE_WORD + 2), '0, '0, 1'b1);
		send_req(OP_READ, addr_t'(RAM_BASE), '0, '0, 1'b1);
		idle_bus();
		wait_drain(10);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* project.f */
soc_bus_pkg.sv
soc_ctrl_pkg.sv
pi1_addr_decode.sv
rst_sequencer.sv
devtbl_regs.sv
gpio_port.sv
scratch_ram.sv
pi1_resp_mux.sv
soc_fabric_top.sv
tb_soc.sv

/* run.sh */
#!/bin/sh
# Compile the fabric testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_soc -f project.f -o tb_soc_sim

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/tb_soc_sim
